//--- verilog.f
bpu_pkg.sv
bpu_update_if.sv
bpu_sdpram.sv
btb.sv
pht.sv
ras.sv
bpu.sv
tb_bpu.sv

//--- Bender.yml
package:
  name: bpu

sources:
  - bpu_pkg.sv
  - bpu_update_if.sv
  - bpu_sdpram.sv
  - btb.sv
  - pht.sv
  - ras.sv
  - bpu.sv
  - target: test
    files:
      - tb_bpu.sv

//--- tb_bpu.sv
// Testbench for the branch prediction unit
//   clock, reset and a cycle-limit timeout
//   reference model of BTB, LRU bits, PHT and RAS
//   comparing process and the single check task
//   directed tests followed by a random mix

module tb_bpu
    import bpu_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 4000;
    localparam int RAND_CYCLES = 1500;

    logic            clk = 1'b0;
    logic            reset;
    logic [PC_W-1:0] lookup_pc;
    logic            update_valid;
    logic [PC_W-1:0] update_pc;
    logic            update_taken;
    logic [PC_W-1:0] update_target;
    logic [1:0]      update_type;
    logic            hit_o;
    logic [1:0]      type_o;
    logic            taken_o;
    logic [PC_W-1:0] target_o;

    integer seed = 32'hbdea_f5db;
    int     error_count = 0;
    int     cycle_count = 0;

    // Model state
    logic                 m_valid  [2][64];
    logic [BTB_TAG_W-1:0] m_tag    [2][64];
    logic [PC_W-1:0]      m_target [2][64];
    logic [1:0]           m_type   [2][64];
    logic                 m_lru    [64];
    logic [1:0]           m_cnt    [256];
    logic [PC_W-1:0]      m_ras    [8];
    logic [2:0]           m_ptr;
    logic                 pend_hit;
    logic [5:0]           pend_set;
    logic                 pend_way;

    bpu dut_i (
        .clk             (clk),
        .reset           (reset),
        .lookup_pc_i     (lookup_pc),
        .update_valid_i  (update_valid),
        .update_pc_i     (update_pc),
        .update_taken_i  (update_taken),
        .update_target_i (update_target),
        .update_type_i   (update_type),
        .hit_o           (hit_o),
        .type_o          (type_o),
        .taken_o         (taken_o),
        .target_o        (target_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("mismatch at %0t: %s actual %h expected %h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    function automatic logic [BTB_TAG_W-1:0] fold_tag(input logic [PC_W-1:0] pc);
        return pc[29:15] ^ pc[14:0];
    endfunction

    // Returns {hit, way} with way 0 preferred
    function automatic logic [1:0] find_way(input logic [PC_W-1:0] pc);
        logic [5:0] set;
        set = pc[5:0];
        if (m_valid[0][set] && m_tag[0][set] == fold_tag(pc)) begin
            return 2'b10;
        end
        if (m_valid[1][set] && m_tag[1][set] == fold_tag(pc)) begin
            return 2'b11;
        end
        return 2'b00;
    endfunction

    // Expected {hit, type, taken, target}
    function automatic logic [PC_W+3:0] predict(input logic [PC_W-1:0] pc);
        logic [1:0]      hw;
        logic [5:0]      set;
        logic [1:0]      ty;
        logic            tk;
        logic [PC_W-1:0] tgt;
        hw  = find_way(pc);
        set = pc[5:0];
        ty  = BR_COND;
        tk  = 1'b0;
        tgt = pc + 1;
        if (hw[1]) begin
            ty = m_type[hw[0]][set];
            if (ty == BR_COND) begin
                tk = m_cnt[pc[7:0]][1];
                tgt = tk ? m_target[hw[0]][set] : pc + 1;
            end else if (ty == BR_RETURN) begin
                tk  = 1'b1;
                tgt = m_ras[m_ptr - 3'd1];
            end else begin
                tk  = 1'b1;
                tgt = m_target[hw[0]][set];
            end
        end
        return {hw[1], ty, tk, tgt};
    endfunction

    task automatic reset_model();
        for (int s = 0; s < 64; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_lru[s] = 1'b0;
        end
        for (int i = 0; i < 256; i++) begin
            m_cnt[i] = 2'd1;
        end
        for (int i = 0; i < 8; i++) begin
            m_ras[i] = '0;
        end
        m_ptr = '0;
        pend_hit = 1'b0;
    endtask

    task automatic apply_update();
        logic [5:0] set;
        logic       v;
        logic [7:0] pi;
        set = update_pc[5:0];
        pi  = update_pc[7:0];
        if (update_valid && update_taken) begin
            v = !m_lru[set];
            m_valid[v][set]  = 1'b1;
            m_tag[v][set]    = fold_tag(update_pc);
            m_target[v][set] = update_target;
            m_type[v][set]   = update_type;
            m_lru[set]       = v;
        end
        if (update_valid && update_type == BR_COND) begin
            if (update_taken && m_cnt[pi] != 2'd3) begin
                m_cnt[pi] = m_cnt[pi] + 2'd1;
            end else if (!update_taken && m_cnt[pi] != 2'd0) begin
                m_cnt[pi] = m_cnt[pi] - 2'd1;
            end
        end
        if (update_valid && update_type == BR_CALL) begin
            m_ras[m_ptr] = update_pc + 1;
            m_ptr = m_ptr + 3'd1;
        end else if (update_valid && update_type == BR_RETURN) begin
            m_ptr = m_ptr - 3'd1;
        end
    endtask

    // Inputs are sampled at the edge and outputs compared mid-cycle
    always begin : compare_proc
        logic [PC_W+3:0] exp_word;
        logic [1:0]      hw;
        @(posedge clk);
        if (reset) begin
            reset_model();
            exp_word = {1'b0, BR_COND, 1'b0, 30'd1};
        end else begin
            // The previous lookup's hit lands before this update's victim choice
            if (pend_hit) begin
                m_lru[pend_set] = pend_way;
            end
            exp_word = predict(lookup_pc);
            hw = find_way(lookup_pc);
            apply_update();
            pend_hit = hw[1];
            pend_set = lookup_pc[5:0];
            pend_way = hw[0];
        end
        @(negedge clk);
        check_value("hit_o", hit_o, exp_word[PC_W+3]);
        check_value("type_o", type_o, exp_word[PC_W+2 -: 2]);
        check_value("taken_o", taken_o, exp_word[PC_W]);
        check_value("target_o", target_o, exp_word[PC_W-1:0]);
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    task automatic drive_cycle(input logic [PC_W-1:0] pc, input logic uv,
                               input logic [PC_W-1:0] upc, input logic utk,
                               input logic [PC_W-1:0] utgt, input logic [1:0] uty);
        @(posedge clk);
        #1;
        lookup_pc     = pc;
        update_valid  = uv;
        update_pc     = upc;
        update_taken  = utk;
        update_target = utgt;
        update_type   = uty;
    endtask

    task automatic lookup_only(input logic [PC_W-1:0] pc);
        drive_cycle(pc, 1'b0, '0, 1'b0, '0, BR_COND);
    endtask

    task automatic commit_branch(input logic [PC_W-1:0] pc, input logic tk,
                                 input logic [PC_W-1:0] tgt, input logic [1:0] ty);
        drive_cycle(pc, 1'b1, pc, tk, tgt, ty);
    endtask

    initial begin : stimulus
        integer r1;
        integer r2;
        reset         = 1'b1;
        lookup_pc     = '0;
        update_valid  = 1'b0;
        update_pc     = '0;
        update_taken  = 1'b0;
        update_target = '0;
        update_type   = BR_COND;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        // Empty tables miss everywhere
        for (int i = 0; i < 64; i++) begin
            lookup_only(30'h1000 + i * 7);
        end

        // Taken jump
        commit_branch(30'h100, 1'b1, 30'h2000, BR_JUMP);
        lookup_only(30'h100);
        lookup_only(30'h100);

        // Conditional counter walk at one address
        // One taken update from weakly not taken already predicts taken
        commit_branch(30'h245, 1'b1, 30'h3000, BR_COND);
        lookup_only(30'h245);
        commit_branch(30'h245, 1'b0, 30'h3000, BR_COND);
        commit_branch(30'h245, 1'b0, 30'h3000, BR_COND);
        commit_branch(30'h245, 1'b1, 30'h3000, BR_COND);
        lookup_only(30'h245);
        commit_branch(30'h245, 1'b1, 30'h3000, BR_COND);
        lookup_only(30'h245);
        commit_branch(30'h245, 1'b1, 30'h3000, BR_COND);
        commit_branch(30'h245, 1'b1, 30'h3000, BR_COND);
        commit_branch(30'h245, 1'b0, 30'h3000, BR_COND);
        lookup_only(30'h245);
        commit_branch(30'h245, 1'b0, 30'h3000, BR_COND);
        lookup_only(30'h245);

        // Three tags in one set with plain replacement
        commit_branch(30'h055, 1'b1, 30'h4001, BR_JUMP);
        commit_branch(30'h095, 1'b1, 30'h4002, BR_JUMP);
        commit_branch(30'h0d5, 1'b1, 30'h4003, BR_JUMP);
        lookup_only(30'h055);
        lookup_only(30'h095);
        lookup_only(30'h0d5);

        // Hit between writes protects the older tag
        commit_branch(30'h06a, 1'b1, 30'h5001, BR_JUMP);
        commit_branch(30'h0aa, 1'b1, 30'h5002, BR_JUMP);
        lookup_only(30'h06a);
        commit_branch(30'h0ea, 1'b1, 30'h5003, BR_JUMP);
        lookup_only(30'h06a);
        lookup_only(30'h0aa);
        lookup_only(30'h0ea);

        // Two calls and a return followed by a wrapping call chain
        commit_branch(30'h300, 1'b1, 30'h800, BR_CALL);
        commit_branch(30'h400, 1'b1, 30'h900, BR_CALL);
        commit_branch(30'h0a0, 1'b1, 30'h000, BR_RETURN);
        lookup_only(30'h0a0);
        for (int i = 0; i < 9; i++) begin
            commit_branch(30'h500 + i, 1'b0, 30'h0, BR_CALL);
        end
        lookup_only(30'h0a0);
        for (int i = 0; i < 9; i++) begin
            commit_branch(30'h0a0, 1'b1, 30'h000, BR_RETURN);
            lookup_only(30'h0a0);
        end

        // Random mix over four sets with eight tags each
        for (int i = 0; i < RAND_CYCLES; i++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            drive_cycle({21'd0, r1[2:0], 4'd0, r1[4:3]}, r1[5],
                        {21'd0, r1[8:6], 4'd0, r1[10:9]}, r1[11],
                        r2[31:2], r2[1:0]);
        end

        lookup_only('0);
        repeat (3) @(posedge clk);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- bpu.sv
// Branch prediction unit top level
//   commit update ports fanned out over the update interface
//   BTB, PHT and RAS instances
//   final taken flag and next fetch address

module bpu
    import bpu_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic [PC_W-1:0] lookup_pc_i,
    input  logic            update_valid_i,
    input  logic [PC_W-1:0] update_pc_i,
    input  logic            update_taken_i,
    input  logic [PC_W-1:0] update_target_i,
    input  logic [1:0]      update_type_i,
    output logic            hit_o,
    output logic [1:0]      type_o,
    output logic            taken_o,
    output logic [PC_W-1:0] target_o
);

    bpu_update_if upd ();

    logic            btb_hit;
    logic [1:0]      btb_type;
    logic [PC_W-1:0] btb_target;
    logic            pht_taken;
    logic [PC_W-1:0] ras_top;
    logic [PC_W-1:0] pc_q;
    logic [PC_W-1:0] fall_through;

    // Commit ports onto the shared bundle
    assign upd.update_valid  = update_valid_i;
    assign upd.update_pc     = update_pc_i;
    assign upd.update_taken  = update_taken_i;
    assign upd.update_target = update_target_i;
    assign upd.update_type   = update_type_i;

    btb u_btb (
        .clk         (clk),
        .reset       (reset),
        .lookup_pc_i (lookup_pc_i),
        .upd         (upd.tables),
        .hit_o       (btb_hit),
        .type_o      (btb_type),
        .target_o    (btb_target)
    );

    pht u_pht (
        .clk         (clk),
        .reset       (reset),
        .lookup_pc_i (lookup_pc_i),
        .upd         (upd.tables),
        .taken_o     (pht_taken)
    );

    ras u_ras (
        .clk   (clk),
        .reset (reset),
        .upd   (upd.tables),
        .top_o (ras_top)
    );

    // Lookup pc delayed to line up with the table outputs
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= '0;
        end else begin
            pc_q <= lookup_pc_i;
        end
    end

    assign fall_through = pc_q + 1'b1;

    // ------------------------------------------------------------------
    // Prediction select
    // ------------------------------------------------------------------

    // On a miss the BTB already presents the fall-through address
    always_comb begin
        hit_o    = btb_hit;
        type_o   = btb_type;
        taken_o  = 1'b0;
        target_o = btb_target;
        if (btb_hit) begin
            case (btb_type)
                BR_COND: begin
                    taken_o  = pht_taken;
                    target_o = pht_taken ? btb_target : fall_through;
                end
                BR_RETURN: begin
                    taken_o  = 1'b1;
                    target_o = ras_top;
                end
                default: begin
                    // Calls and jumps are always taken
                    taken_o  = 1'b1;
                    target_o = btb_target;
                end
            endcase
        end
    end

endmodule

//--- ras.sv
// Return address stack
//   circular buffer with a single pointer
//   push of pc+1 on committed calls, pop on committed returns
//   registered top of stack for the lookup stage

module ras
    import bpu_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    bpu_update_if.tables    upd,
    output logic [PC_W-1:0] top_o
);

    logic [PC_W-1:0]      stack [RAS_DEPTH];
    logic [RAS_PTR_W-1:0] ptr;
    logic [RAS_PTR_W-1:0] top_ptr;
    logic                 push;
    logic                 pop;
    logic [PC_W-1:0]      ret_addr;

    assign push     = upd.update_valid && (upd.update_type == BR_CALL);
    assign pop      = upd.update_valid && (upd.update_type == BR_RETURN);
    assign ret_addr = upd.update_pc + 1'b1;

    // Entry just below the pointer, wraps around the buffer
    assign top_ptr = ptr - 1'b1;

    // ------------------------------------------------------------------
    // Stack storage and pointer
    // ------------------------------------------------------------------

    // When full a push silently overwrites the oldest entry
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RAS_DEPTH; i++) begin
                stack[i] <= '0;
            end
        end else if (push) begin
            stack[ptr] <= ret_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (push) begin
            ptr <= ptr + 1'b1;
        end else if (pop) begin
            ptr <= ptr - 1'b1;
        end
    end

    // Sampled with the lookup so a same-cycle update is not seen
    always_ff @(posedge clk) begin
        if (reset) begin
            top_o <= '0;
        end else begin
            top_o <= stack[top_ptr];
        end
    end

endmodule

//--- pht.sv
// Pattern history table
//   2-bit saturating counters indexed by word address bits 7:0
//   registered read, taken is the counter's high bit
//   counter moves toward the outcome of committed conditional branches

module pht
    import bpu_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic [PC_W-1:0] lookup_pc_i,
    bpu_update_if.tables    upd,
    output logic            taken_o
);

    localparam int ENTRIES = 2 ** PHT_INDEX_W;

    logic [1:0]             cnt [ENTRIES];
    logic [PHT_INDEX_W-1:0] rd_index;
    logic [PHT_INDEX_W-1:0] wr_index;
    logic                   wr_en;
    logic [1:0]             cnt_old;
    logic [1:0]             cnt_new;

    assign rd_index = lookup_pc_i[PHT_INDEX_W-1:0];
    assign wr_index = upd.update_pc[PHT_INDEX_W-1:0];
    assign wr_en    = upd.update_valid && (upd.update_type == BR_COND);
    assign cnt_old  = cnt[wr_index];

    // Saturate at 0 and 3
    always_comb begin
        cnt_new = cnt_old;
        if (upd.update_taken) begin
            if (cnt_old != 2'd3) begin
                cnt_new = cnt_old + 2'd1;
            end
        end else if (cnt_old != 2'd0) begin
            cnt_new = cnt_old - 2'd1;
        end
    end

    // Counters start weakly not taken
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                cnt[i] <= 2'd1;
            end
        end else if (wr_en) begin
            cnt[wr_index] <= cnt_new;
        end
    end

    // Read sees the counter from before a same-edge update
    always_ff @(posedge clk) begin
        if (reset) begin
            taken_o <= 1'b0;
        end else begin
            taken_o <= cnt[rd_index][1];
        end
    end

endmodule

//--- btb.sv
// Two-way set-associative branch target buffer
//   one RAM per way, tag compare one cycle after lookup
//   one LRU bit per set, victim is the other way
//   fall-through target and BR_COND type on a miss

module btb
    import bpu_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic [PC_W-1:0] lookup_pc_i,
    bpu_update_if.tables    upd,
    output logic            hit_o,
    output logic [1:0]      type_o,
    output logic [PC_W-1:0] target_o
);

    localparam int SETS = 2 ** BTB_INDEX_W;

    // Lookup side
    logic [BTB_INDEX_W-1:0] lookup_index;
    logic [BTB_TAG_W-1:0]   lookup_tag;
    logic [PC_W-1:0]        pre_pc;
    logic [BTB_INDEX_W-1:0] pre_index;
    logic [BTB_TAG_W-1:0]   pre_tag;

    // Update side
    logic [BTB_INDEX_W-1:0] upd_index;
    logic [BTB_TAG_W-1:0]   upd_tag;
    logic                   wr_en;
    logic [BTB_ENTRY_W-1:0] wr_entry;

    // Per-way read data
    logic [BTB_ENTRY_W-1:0] rd_entry   [2];
    logic [1:0]             way_valid;
    logic [BTB_TAG_W-1:0]   way_tag    [2];
    logic [PC_W-1:0]        way_target [2];
    logic [1:0]             way_type   [2];
    logic [1:0]             match;
    logic [1:0]             we_way;

    // Replacement state
    logic [SETS-1:0] lru;
    logic            hit;
    logic            hit_way;
    logic            lru_cur;
    logic            victim;

    assign lookup_index = lookup_pc_i[BTB_INDEX_W-1:0];
    assign lookup_tag   = btb_tag(lookup_pc_i);

    assign upd_index = upd.update_pc[BTB_INDEX_W-1:0];
    assign upd_tag   = btb_tag(upd.update_pc);
    assign wr_en     = upd.update_valid && upd.update_taken;
    assign wr_entry  = {1'b1, upd_tag, upd.update_target, upd.update_type};

    // Lookup stage register, lines up with the RAM read data
    always_ff @(posedge clk) begin
        if (reset) begin
            pre_pc    <= '0;
            pre_index <= '0;
            pre_tag   <= '0;
        end else begin
            pre_pc    <= lookup_pc_i;
            pre_index <= lookup_index;
            pre_tag   <= lookup_tag;
        end
    end

    // ------------------------------------------------------------------
    // Way storage and tag compare
    // ------------------------------------------------------------------

    for (genvar w = 0; w < 2; w++) begin : g_way
        bpu_sdpram #(
            .ADDR_W (BTB_INDEX_W),
            .DATA_W (BTB_ENTRY_W)
        ) u_ram (
            .clk     (clk),
            .reset   (reset),
            .we_i    (we_way[w]),
            .waddr_i (upd_index),
            .wdata_i (wr_entry),
            .raddr_i (lookup_index),
            .rdata_o (rd_entry[w])
        );

        assign way_valid[w]  = rd_entry[w][BTB_ENTRY_W-1];
        assign way_tag[w]    = rd_entry[w][BTB_ENTRY_W-2 -: BTB_TAG_W];
        assign way_target[w] = rd_entry[w][PC_W+1 -: PC_W];
        assign way_type[w]   = rd_entry[w][1:0];
        assign match[w]      = way_valid[w] && (way_tag[w] == pre_tag);
    end

    assign hit = |match;
    // Way 0 wins when both ways match
    assign hit_way = !match[0];

    always_comb begin
        hit_o    = hit;
        type_o   = BR_COND;
        target_o = pre_pc + 1'b1;
        if (match[0]) begin
            type_o   = way_type[0];
            target_o = way_target[0];
        end else if (match[1]) begin
            type_o   = way_type[1];
            target_o = way_target[1];
        end
    end

    // ------------------------------------------------------------------
    // LRU and victim selection
    // ------------------------------------------------------------------

    // A hit in the same set this cycle counts before the write
    assign lru_cur = (hit && (pre_index == upd_index)) ? hit_way : lru[upd_index];
    assign victim  = !lru_cur;
    assign we_way  = wr_en ? (victim ? 2'b10 : 2'b01) : 2'b00;

    // Write comes last so it decides the bit on a same-set collision
    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else begin
            if (hit) begin
                lru[pre_index] <= hit_way;
            end
            if (wr_en) begin
                lru[upd_index] <= victim;
            end
        end
    end

endmodule

//--- bpu_sdpram.sv
// Simple dual-port RAM
//   one write port, one registered read port
//   read-first on an address collision
//   synchronous clear of every word

module bpu_sdpram #(
    parameter int ADDR_W = 6,
    parameter int DATA_W = 48
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] waddr_i,
    input  logic [DATA_W-1:0] wdata_i,
    input  logic [ADDR_W-1:0] raddr_i,
    output logic [DATA_W-1:0] rdata_o
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [DATA_W-1:0] mem [DEPTH];

    // Clearing the words is what invalidates every BTB entry
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Nonblocking read returns the word from before a same-edge write
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_o <= '0;
        end else begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

//--- bpu_update_if.sv
// Commit-time update bundle shared by the BTB, PHT and RAS
//   source modport drives the update
//   tables modport receives it

interface bpu_update_if
    import bpu_pkg::*;
();

    // Single-cycle strobe, no back-pressure
    logic            update_valid;
    logic [PC_W-1:0] update_pc;
    logic            update_taken;
    logic [PC_W-1:0] update_target;
    logic [1:0]      update_type;

    // Commit side
    modport source (
        output update_valid,
        output update_pc,
        output update_taken,
        output update_target,
        output update_type
    );

    // BTB, PHT and RAS side
    modport tables (
        input update_valid,
        input update_pc,
        input update_taken,
        input update_target,
        input update_type
    );

endinterface

//--- bpu_pkg.sv
// Shared definitions for the branch prediction unit
//   word address width and table geometry
//   branch type codes
//   BTB tag fold function

package bpu_pkg;

    // ------------------------------------------------------------------
    // Widths and table sizes
    // ------------------------------------------------------------------

    // Word address, pc bits 31 down to 2
    localparam int PC_W = 30;

    // BTB geometry, 64 sets of two ways
    localparam int BTB_INDEX_W = 6;
    localparam int BTB_TAG_W   = 15;

    // Entry layout is {valid, tag, target, type}
    localparam int BTB_ENTRY_W = 1 + BTB_TAG_W + PC_W + 2;

    // PHT and RAS sizes
    localparam int PHT_INDEX_W = 8;
    localparam int RAS_DEPTH   = 8;
    localparam int RAS_PTR_W   = 3;

    // ------------------------------------------------------------------
    // Branch type codes
    // ------------------------------------------------------------------

    localparam logic [1:0] BR_COND   = 2'd0;
    localparam logic [1:0] BR_CALL   = 2'd1;
    localparam logic [1:0] BR_RETURN = 2'd2;
    localparam logic [1:0] BR_JUMP   = 2'd3;

    // Fold pc[31:17] onto pc[16:2], given the word address pc[31:2]
    function automatic logic [BTB_TAG_W-1:0] btb_tag(input logic [PC_W-1:0] pc);
        logic [BTB_TAG_W-1:0] hi_part;
        logic [BTB_TAG_W-1:0] lo_part;
        hi_part = pc[PC_W-1 -: BTB_TAG_W];
        lo_part = pc[BTB_TAG_W-1:0];
        return hi_part ^ lo_part;
    endfunction

endpackage
